// File: ctl_cmd_tracker.f
+incdir+include
src/ctl_tracker_pkg.sv
src/ctl_list.sv
src/ctl_cmd_intake.sv
src/ctl_cmd_store.sv
src/ctl_cmd_issue.sv
src/ctl_cmd_tracker.sv
tb/ctl_cmd_tracker_checker.sv
tb/ctl_cmd_tracker_tb.sv

// File: include/ctl_tracker_consts.svh
`ifndef CTL_TRACKER_CONSTS_SVH
`define CTL_TRACKER_CONSTS_SVH

// number of command tags in flight
`define CTL_TRK_DEPTH 8

// tag id width
`define CTL_TRK_ID_WIDTH 3

// host command payload
`define CTL_TRK_PAYLOAD_WIDTH 16

`endif

// File: run_sim.sh
#!/bin/bash
# build and run the command tracker simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f ctl_cmd_tracker.f \
    --top-module ctl_cmd_tracker_tb \
    -Mdir obj_dir -o ctl_cmd_tracker_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/ctl_cmd_tracker_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$SIM_LOG"; then
    exit 0
fi
exit 1

// File: src/ctl_cmd_intake.sv
`timescale 1ns/1ps

module ctl_cmd_intake (
    input  logic                          ctl_clk,
    input  logic                          ctl_reset_n,
    input  logic                          cmd_req,
    input  ctl_tracker_pkg::ctl_payload_t cmd_payload,
    input  logic                          free_valid,
    input  ctl_tracker_pkg::ctl_id_t      free_id,
    output logic                          cmd_ack,
    output ctl_tracker_pkg::ctl_id_t      cmd_id,
    output logic                          free_get,
    output logic                          order_put,
    output ctl_tracker_pkg::ctl_id_t      order_put_id,
    output logic                          store_we,
    output ctl_tracker_pkg::ctl_id_t      store_wr_id,
    output ctl_tracker_pkg::ctl_payload_t store_wr_data
);

    import ctl_tracker_pkg::*;

    intake_state_t state;
    logic          accept;

    // take a command only when a tag is on hand
    assign accept = (state == IN_IDLE) && cmd_req && free_valid;

    // allocation, payload write and queueing all happen on the accept cycle
    assign free_get      = accept;
    assign order_put     = accept;
    assign order_put_id  = free_id;
    assign store_we      = accept;
    assign store_wr_id   = free_id;
    assign store_wr_data = cmd_payload;

    assign cmd_ack = (state == IN_ACK);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            state <= IN_IDLE;
        end
        else
        begin
            case (state)
                IN_IDLE:
                begin
                    if (accept)
                    begin
                        state <= IN_ACK;
                    end
                end
                IN_ACK:
                begin
                    // host released req, drop ack
                    if (!cmd_req)
                    begin
                        state <= IN_IDLE;
                    end
                end
            endcase
        end
    end

    // tag returned to host, held for the whole ack phase
    always_ff @(posedge ctl_clk)
    begin
        if (accept)
        begin
            cmd_id <= free_id;
        end
    end

endmodule

// File: src/ctl_cmd_issue.sv
`timescale 1ns/1ps

module ctl_cmd_issue (
    input  logic                          ctl_clk,
    input  logic                          ctl_reset_n,
    input  logic                          order_valid,
    input  ctl_tracker_pkg::ctl_id_t      order_id,
    input  ctl_tracker_pkg::ctl_payload_t rd_data,
    input  logic                          mem_ack,
    output logic                          order_get,
    output logic                          free_put,
    output ctl_tracker_pkg::ctl_id_t      free_put_id,
    output logic                          mem_req,
    output ctl_tracker_pkg::ctl_id_t      mem_id,
    output ctl_tracker_pkg::ctl_payload_t mem_payload
);

    import ctl_tracker_pkg::*;

    issue_state_t state;
    logic         load;
    logic         done;

    // oldest pending command gets picked up from idle
    assign load = (state == IS_IDLE) && order_valid;

    // completion retires the head and recycles its tag
    assign done = (state == IS_REQ) && mem_ack;

    assign order_get   = done;
    assign free_put    = done;
    assign free_put_id = mem_id;
    assign mem_req     = (state == IS_REQ);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            state <= IS_IDLE;
        end
        else
        begin
            case (state)
                IS_IDLE:
                begin
                    if (load)
                    begin
                        state <= IS_REQ;
                    end
                end
                IS_REQ:
                begin
                    if (done)
                    begin
                        state <= IS_RELEASE;
                    end
                end
                IS_RELEASE:
                begin
                    // wait for memory side to drop ack
                    if (!mem_ack)
                    begin
                        state <= IS_IDLE;
                    end
                end
                default:
                begin
                    state <= IS_IDLE;
                end
            endcase
        end
    end

    // held stable while mem_req is up
    always_ff @(posedge ctl_clk)
    begin
        if (load)
        begin
            mem_id      <= order_id;
            mem_payload <= rd_data;
        end
    end

endmodule

// File: src/ctl_cmd_store.sv
`timescale 1ns/1ps
`include "ctl_tracker_consts.svh"

module ctl_cmd_store (
    input  logic                          ctl_clk,
    input  logic                          ctl_reset_n,
    input  logic                          store_we,
    input  ctl_tracker_pkg::ctl_id_t      store_wr_id,
    input  ctl_tracker_pkg::ctl_payload_t store_wr_data,
    input  ctl_tracker_pkg::ctl_id_vec_t  rd_sel,
    output ctl_tracker_pkg::ctl_payload_t rd_data
);

    import ctl_tracker_pkg::*;

    // one entry per tag
    ctl_payload_t payload_reg [`CTL_TRK_DEPTH];

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            for (int i = 0; i < `CTL_TRK_DEPTH; i++)
            begin
                payload_reg[i] <= '0;
            end
        end
        else if (store_we)
        begin
            payload_reg[store_wr_id] <= store_wr_data;
        end
    end

    // and-or mux on the one-hot select, zero when nothing selected
    always_comb
    begin
        rd_data = '0;
        for (int i = 0; i < `CTL_TRK_DEPTH; i++)
        begin
            rd_data = rd_data | ({`CTL_TRK_PAYLOAD_WIDTH{rd_sel[i]}} & payload_reg[i]);
        end
    end

endmodule

// File: src/ctl_cmd_tracker.sv
`timescale 1ns/1ps
`include "ctl_tracker_consts.svh"

module ctl_cmd_tracker (
    input  logic                          ctl_clk,
    input  logic                          ctl_reset_n,
    input  logic                          cmd_req,
    input  ctl_tracker_pkg::ctl_payload_t cmd_payload,
    input  logic                          mem_ack,
    output logic                          cmd_ack,
    output ctl_tracker_pkg::ctl_id_t      cmd_id,
    output logic                          mem_req,
    output ctl_tracker_pkg::ctl_id_t      mem_id,
    output ctl_tracker_pkg::ctl_payload_t mem_payload
);

    import ctl_tracker_pkg::*;

    logic         free_valid;
    ctl_id_t      free_id;
    logic         free_get;
    logic         free_put;
    ctl_id_t      free_put_id;
    logic         order_valid;
    ctl_id_t      order_id;
    ctl_id_vec_t  order_vec;
    logic         order_get;
    logic         order_put;
    ctl_id_t      order_put_id;
    logic         store_we;
    ctl_id_t      store_wr_id;
    ctl_payload_t store_wr_data;
    ctl_payload_t rd_data;

    // tag count bounds both lists so neither needs its ready output
    ctl_list #(
        .CTL_LIST_DEPTH           (`CTL_TRK_DEPTH),
        .CTL_LIST_WIDTH           (`CTL_TRK_ID_WIDTH),
        .CTL_LIST_INIT_VALUE_TYPE ("INCR"),
        .CTL_LIST_INIT_VALID      ("VALID")
    ) u_free_list (
        .ctl_clk                  (ctl_clk),
        .ctl_reset_n              (ctl_reset_n),
        .list_get                 (free_get),
        .list_put                 (free_put),
        .list_put_entry_id        (free_put_id),
        .list_get_entry_valid     (free_valid),
        .list_get_entry_id        (free_id),
        .list_get_entry_id_vector (),
        .list_put_entry_ready     ()
    );

    // acceptance order of outstanding tags
    ctl_list #(
        .CTL_LIST_DEPTH           (`CTL_TRK_DEPTH),
        .CTL_LIST_WIDTH           (`CTL_TRK_ID_WIDTH),
        .CTL_LIST_INIT_VALUE_TYPE ("ZERO"),
        .CTL_LIST_INIT_VALID      ("INVALID")
    ) u_order_list (
        .ctl_clk                  (ctl_clk),
        .ctl_reset_n              (ctl_reset_n),
        .list_get                 (order_get),
        .list_put                 (order_put),
        .list_put_entry_id        (order_put_id),
        .list_get_entry_valid     (order_valid),
        .list_get_entry_id        (order_id),
        .list_get_entry_id_vector (order_vec),
        .list_put_entry_ready     ()
    );

    ctl_cmd_intake u_intake (
        .ctl_clk       (ctl_clk),
        .ctl_reset_n   (ctl_reset_n),
        .cmd_req       (cmd_req),
        .cmd_payload   (cmd_payload),
        .free_valid    (free_valid),
        .free_id       (free_id),
        .cmd_ack       (cmd_ack),
        .cmd_id        (cmd_id),
        .free_get      (free_get),
        .order_put     (order_put),
        .order_put_id  (order_put_id),
        .store_we      (store_we),
        .store_wr_id   (store_wr_id),
        .store_wr_data (store_wr_data)
    );

    ctl_cmd_store u_store (
        .ctl_clk       (ctl_clk),
        .ctl_reset_n   (ctl_reset_n),
        .store_we      (store_we),
        .store_wr_id   (store_wr_id),
        .store_wr_data (store_wr_data),
        .rd_sel        (order_vec),
        .rd_data       (rd_data)
    );

    ctl_cmd_issue u_issue (
        .ctl_clk       (ctl_clk),
        .ctl_reset_n   (ctl_reset_n),
        .order_valid   (order_valid),
        .order_id      (order_id),
        .rd_data       (rd_data),
        .mem_ack       (mem_ack),
        .order_get     (order_get),
        .free_put      (free_put),
        .free_put_id   (free_put_id),
        .mem_req       (mem_req),
        .mem_id        (mem_id),
        .mem_payload   (mem_payload)
    );

endmodule

// File: src/ctl_list.sv
`timescale 1ns/1ps
`include "ctl_tracker_consts.svh"

module ctl_list #(
    parameter int CTL_LIST_DEPTH           = `CTL_TRK_DEPTH,
    parameter int CTL_LIST_WIDTH           = `CTL_TRK_ID_WIDTH,
    parameter     CTL_LIST_INIT_VALUE_TYPE = "INCR",
    parameter     CTL_LIST_INIT_VALID      = "VALID"
) (
    input  logic                         ctl_clk,
    input  logic                         ctl_reset_n,
    input  logic                         list_get,
    input  logic                         list_put,
    input  ctl_tracker_pkg::ctl_id_t     list_put_entry_id,
    output logic                         list_get_entry_valid,
    output ctl_tracker_pkg::ctl_id_t     list_get_entry_id,
    output ctl_tracker_pkg::ctl_id_vec_t list_get_entry_id_vector,
    output logic                         list_put_entry_ready
);

    // slot 0 is the head
    logic [CTL_LIST_WIDTH-1:0] list_id [CTL_LIST_DEPTH];
    logic [CTL_LIST_DEPTH-1:0] list_v;
    logic [CTL_LIST_DEPTH-1:0] list_vector;

    function automatic logic [CTL_LIST_DEPTH-1:0] one_hot(
        input logic [CTL_LIST_WIDTH-1:0] id
    );
        logic [CTL_LIST_DEPTH-1:0] vec;
        vec     = '0;
        vec[id] = 1'b1;
        return vec;
    endfunction

    assign list_get_entry_valid     = list_v[0];
    assign list_get_entry_id        = list_id[0];
    assign list_get_entry_id_vector = list_vector;
    assign list_put_entry_ready     = ~list_v[CTL_LIST_DEPTH-1];

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            for (int i = 0; i < CTL_LIST_DEPTH; i++)
            begin
                if (CTL_LIST_INIT_VALUE_TYPE == "INCR")
                begin
                    list_id[i] <= CTL_LIST_WIDTH'(i);
                end
                else
                begin
                    list_id[i] <= '0;
                end
                list_v[i] <= (CTL_LIST_INIT_VALID == "VALID");
            end
            // a prefilled list has entry zero at the head
            list_vector <= (CTL_LIST_INIT_VALID == "VALID") ? one_hot('0) : '0;
        end
        else if (list_get && list_put)
        begin
            // shift toward head, then the put lands one slot below the old tail
            for (int i = 1; i < CTL_LIST_DEPTH; i++)
            begin
                list_v[i-1]  <= list_v[i];
                list_id[i-1] <= list_id[i];
            end
            list_v[CTL_LIST_DEPTH-1] <= 1'b0;
            for (int i = 1; i < CTL_LIST_DEPTH; i++)
            begin
                if (list_v[i-1] && !list_v[i])
                begin
                    list_v[i-1]  <= 1'b1;
                    list_id[i-1] <= list_put_entry_id;
                end
            end
            if (!list_v[0])
            begin
                list_v[0]  <= 1'b1;
                list_id[0] <= list_put_entry_id;
            end
            // full list keeps its tail slot for the new entry
            if (list_v[CTL_LIST_DEPTH-1])
            begin
                list_v[CTL_LIST_DEPTH-1]  <= 1'b1;
                list_id[CTL_LIST_DEPTH-1] <= list_put_entry_id;
            end
            list_vector <= list_v[1] ? one_hot(list_id[1]) : one_hot(list_put_entry_id);
        end
        else if (list_get)
        begin
            for (int i = 1; i < CTL_LIST_DEPTH; i++)
            begin
                list_v[i-1]  <= list_v[i];
                list_id[i-1] <= list_id[i];
            end
            list_v[CTL_LIST_DEPTH-1] <= 1'b0;
            list_vector <= list_v[1] ? one_hot(list_id[1]) : '0;
        end
        else if (list_put)
        begin
            // first empty slot takes the entry
            if (!list_v[0])
            begin
                list_v[0]   <= 1'b1;
                list_id[0]  <= list_put_entry_id;
                list_vector <= one_hot(list_put_entry_id);
            end
            for (int i = 1; i < CTL_LIST_DEPTH; i++)
            begin
                if (list_v[i-1] && !list_v[i])
                begin
                    list_v[i]  <= 1'b1;
                    list_id[i] <= list_put_entry_id;
                end
            end
        end
    end

endmodule

// File: src/ctl_tracker_pkg.sv
`include "ctl_tracker_consts.svh"

package ctl_tracker_pkg;

    // tag as carried on both links
    typedef logic [`CTL_TRK_ID_WIDTH-1:0] ctl_id_t;

    // one bit per tag
    typedef logic [`CTL_TRK_DEPTH-1:0] ctl_id_vec_t;

    typedef logic [`CTL_TRK_PAYLOAD_WIDTH-1:0] ctl_payload_t;

    // host side handshake
    typedef enum logic {IN_IDLE, IN_ACK} intake_state_t;

    // memory side handshake
    typedef enum logic [1:0] {IS_IDLE, IS_REQ, IS_RELEASE} issue_state_t;

endpackage

// File: tb/ctl_cmd_tracker_checker.sv
`timescale 1ns/1ps

module ctl_cmd_tracker_checker (
    input logic                          ctl_clk,
    input logic                          ctl_reset_n,
    input logic                          cmd_req,
    input logic                          cmd_ack,
    input ctl_tracker_pkg::ctl_id_t      cmd_id,
    input logic                          mem_req,
    input logic                          mem_ack,
    input ctl_tracker_pkg::ctl_payload_t mem_payload,
    input logic                          free_valid,
    input logic                          order_valid,
    input logic                          order_get
);

    // host link four-phase ordering
    a_cmd_no_ack_without_req: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (!cmd_req && !cmd_ack) |=> !cmd_ack) else $error("cmd_ack rose without cmd_req");
    a_cmd_ack_drops: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (!cmd_req && cmd_ack) |=> !cmd_ack) else $error("cmd_ack held after cmd_req fell");

    // memory link four-phase ordering
    a_mem_req_holds: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (mem_req && !mem_ack) |=> mem_req) else $error("mem_req dropped before mem_ack");
    a_mem_req_drops: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (mem_req && mem_ack) |=> !mem_req) else $error("mem_req held after mem_ack");
    a_mem_no_rerequest: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (!mem_req && mem_ack) |=> !mem_req) else $error("mem_req rose while mem_ack high");

    // link data held through the handshake
    a_cmd_id_stable: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (cmd_ack && $past(cmd_ack)) |-> (cmd_id == $past(cmd_id)))
        else $error("cmd_id changed during cmd_ack");
    a_mem_payload_stable: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (mem_req && $past(mem_req)) |-> (mem_payload == $past(mem_payload)))
        else $error("mem_payload changed during mem_req");

    // every tag sits in one of the lists and retires only from a valid head
    a_lists_not_both_empty: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        free_valid || order_valid) else $error("free and order lists both empty");
    a_order_get_valid: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        order_get |-> order_valid) else $error("order list popped while empty");

endmodule

bind ctl_cmd_tracker ctl_cmd_tracker_checker u_checker (
    .ctl_clk     (ctl_clk),
    .ctl_reset_n (ctl_reset_n),
    .cmd_req     (cmd_req),
    .cmd_ack     (cmd_ack),
    .cmd_id      (cmd_id),
    .mem_req     (mem_req),
    .mem_ack     (mem_ack),
    .mem_payload (mem_payload),
    .free_valid  (free_valid),
    .order_valid (order_valid),
    .order_get   (order_get)
);

// File: tb/ctl_cmd_tracker_tb.sv
`timescale 1ns/1ps
`include "ctl_tracker_consts.svh"

module ctl_cmd_tracker_tb;

    import ctl_tracker_pkg::*;

    localparam int N_RANDOM    = 40;
    localparam int N_STALL     = `CTL_TRK_DEPTH + 1;
    localparam int N_B2B       = 60;
    localparam int N_TOTAL     = N_RANDOM + N_STALL + N_B2B;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_HOLD   = 1;
    localparam int MODE_FAST   = 2;

    logic         ctl_clk;
    logic         ctl_reset_n;
    logic         cmd_req;
    ctl_payload_t cmd_payload;
    logic         mem_ack;
    logic         cmd_ack;
    ctl_id_t      cmd_id;
    logic         mem_req;
    ctl_id_t      mem_id;
    ctl_payload_t mem_payload;

    integer       seed;
    int           mem_mode;
    int           accept_count;
    int           done_count;
    logic         prev_ack;
    logic         prev_req;

    // reference model
    ctl_id_t      free_q[$];
    ctl_id_t      pend_id[$];
    ctl_payload_t pend_pl[$];

    ctl_cmd_tracker UUT (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd_req     (cmd_req),
        .cmd_payload (cmd_payload),
        .mem_ack     (mem_ack),
        .cmd_ack     (cmd_ack),
        .cmd_id      (cmd_id),
        .mem_req     (mem_req),
        .mem_id      (mem_id),
        .mem_payload (mem_payload)
    );

    initial
    begin
        ctl_clk = 1'b0;
    end

    always #5 ctl_clk = ~ctl_clk;

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_id(input string name, input ctl_id_t exp, input ctl_id_t act);
        if (act !== exp)
        begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_payload(input string name, input ctl_payload_t exp,
                                 input ctl_payload_t act);
        if (act !== exp)
        begin
            $display("Error at %0t: %s expected 0x%04h, got 0x%04h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped");
        end
    endtask

    // host request raised on a falling edge
    task automatic raise_req();
        logic [31:0] r;
        r           = $random(seed);
        cmd_payload = r[15:0];
        cmd_req     = 1'b1;
    endtask

    task automatic complete_cmd();
        while (!cmd_ack)
        begin
            @(negedge ctl_clk);
        end
        cmd_req = 1'b0;
        while (cmd_ack)
        begin
            @(negedge ctl_clk);
        end
    endtask

    task automatic send_cmd(input int gap);
        repeat (gap) @(negedge ctl_clk);
        raise_req();
        complete_cmd();
    endtask

    task automatic wait_drained();
        while (pend_id.size() != 0 || mem_req || mem_ack)
        begin
            @(negedge ctl_clk);
        end
    endtask

    // memory agent
    initial
    begin
        logic [31:0] r;
        int          delay;
        forever
        begin
            @(negedge ctl_clk);
            if (ctl_reset_n && mem_req && !mem_ack && mem_mode != MODE_HOLD)
            begin
                r = $random(seed);
                if (mem_mode == MODE_FAST)
                    delay = int'(r[0]);
                else if (r[6:4] == 3'd0)
                    delay = 15;
                else
                    delay = int'(r[3:0]);
                repeat (delay) @(negedge ctl_clk);
                mem_ack = 1'b1;
                while (mem_req)
                begin
                    @(negedge ctl_clk);
                end
                mem_ack = 1'b0;
            end
        end
    end

    // acceptance first, then completion, matching the list put order
    always @(negedge ctl_clk)
    begin
        if (!ctl_reset_n)
        begin
            prev_ack = 1'b0;
            prev_req = 1'b0;
        end
        else
        begin
            if (cmd_ack && !prev_ack)
            begin
                if (free_q.size() == 0)
                    abort_run("command accepted with no free tag in the model");
                check_id("cmd_id", free_q[0], cmd_id);
                void'(free_q.pop_front());
                pend_id.push_back(cmd_id);
                pend_pl.push_back(cmd_payload);
                accept_count++;
            end
            if (mem_req && !prev_req)
            begin
                if (pend_id.size() == 0)
                    abort_run("memory request with no pending command");
                check_id("mem_id", pend_id[0], mem_id);
                check_payload("mem_payload", pend_pl[0], mem_payload);
            end
            if (!mem_req && prev_req)
            begin
                free_q.push_back(pend_id.pop_front());
                void'(pend_pl.pop_front());
                done_count++;
            end
            prev_ack = cmd_ack;
            prev_req = mem_req;
        end
    end

    initial
    begin
        repeat (N_TOTAL * 40 + 200) @(posedge ctl_clk);
        $display("watchdog expired, the run did not finish in time");
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    end

    initial
    begin
        logic [31:0] r;
        int          stall_done;
        seed         = 24;
        cmd_req      = 1'b0;
        cmd_payload  = '0;
        mem_ack      = 1'b0;
        mem_mode     = MODE_RANDOM;
        accept_count = 0;
        done_count   = 0;
        ctl_reset_n  = 1'b0;
        for (int i = 0; i < `CTL_TRK_DEPTH; i++)
        begin
            free_q.push_back(ctl_id_t'(i));
        end
        repeat (10) @(posedge ctl_clk);
        @(negedge ctl_clk);
        ctl_reset_n = 1'b1;
        @(negedge ctl_clk);
        check_bit("cmd_ack", 1'b0, cmd_ack);
        check_bit("mem_req", 1'b0, mem_req);

        // random gaps and memory latency
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = $random(seed);
            send_cmd(int'(r[2:0]));
        end
        wait_drained();

        // all tags outstanding while the memory side stalls
        mem_mode = MODE_HOLD;
        for (int i = 0; i < `CTL_TRK_DEPTH; i++)
        begin
            send_cmd(0);
        end
        if (free_q.size() != 0)
            abort_run("tags still free after filling the tracker");
        raise_req();
        repeat (30)
        begin
            @(negedge ctl_clk);
            check_bit("cmd_ack", 1'b0, cmd_ack);
        end
        stall_done = done_count;
        mem_mode   = MODE_RANDOM;
        complete_cmd();
        if (done_count == stall_done)
            abort_run("cmd_ack rose before any tag was freed");
        wait_drained();

        // back to back with fast completions
        mem_mode = MODE_FAST;
        for (int i = 0; i < N_B2B; i++)
        begin
            send_cmd(0);
        end
        wait_drained();

        if (done_count != accept_count || free_q.size() != `CTL_TRK_DEPTH)
            abort_run("command count mismatch at end of run");
        $display("=== PASS ===");
        $finish;
    end

endmodule
